// File: hw/aesSboxTable.svh
// ******************************
// forward AES S-box only, no inverse table
// needs byte_t in scope before it is included
// ******************************

`ifndef AES_SBOX_TABLE_SVH
`define AES_SBOX_TABLE_SVH

    // entry n is the substitute of byte value n
    localparam byte_t SBOX_TABLE [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

`endif

// File: hw/aesPkg.sv
// ******************************
// AES-128 only: ten rounds, 128-bit key and block
// the S-box table comes from aesSboxTable.svh on the include path
// ******************************

package aesPkg;

    // one byte of key or state
    typedef logic [7:0] byte_t;

    // a column of four bytes, byte 0 is the most significant
    typedef byte_t [0:3] word_t;

    // key, plaintext, ciphertext and single round keys
    typedef logic [127:0] block_t;

    // the cipher state seen either as bytes or as columns
    // bytes are in column-major order, so bytes[4*c + r] is row r of column c
    typedef union packed {
        byte_t [0:15] bytes;
        word_t [0:3]  cols;
    } aesState_u;

    // number of cipher rounds after the initial key addition
    localparam int NUM_ROUNDS = 10;

    // round key 0 is the raw key, round key 10 is used by the final round
    typedef block_t [0:NUM_ROUNDS] roundKeys_t;

    // index into the round keys, 0 to 10
    typedef logic [3:0] roundIdx_t;

`include "aesSboxTable.svh"

    // forward S-box substitution of one byte
    function automatic byte_t sboxLookup(input byte_t in);
        return SBOX_TABLE[in];
    endfunction

endpackage

// File: hw/expandKey.sv
// ******************************
// AES-128 key schedule, fully combinational
// all eleven round keys settle in one pass, a long path
// ******************************

`timescale 1ns/1ps

module expandKey
    import aesPkg::*;
(
    input  block_t     key,
    output roundKeys_t roundKeys
);

    // round constants for schedule steps 1 to 10, applied to byte 0
    localparam byte_t RCON [1:NUM_ROUNDS] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // one round key as four columns
    typedef word_t [0:3] keyCols_t;

    keyCols_t [0:NUM_ROUNDS] keyBlocks;

    // rotate the column up by one byte
    function automatic word_t rotWord(input word_t in);
        return {in[1], in[2], in[3], in[0]};
    endfunction

    // substitute each byte of the column
    function automatic word_t subWord(input word_t in);
        word_t out;
        for (int i = 0; i < 4; i++)
        begin
            out[i] = sboxLookup(in[i]);
        end
        return out;
    endfunction

    // derive round key n from round key n-1
    function automatic keyCols_t nextBlock(input int step, input keyCols_t prev);
        keyCols_t next;
        word_t    temp;
        temp = subWord(rotWord(prev[3]));
        temp[0] = temp[0] ^ RCON[step];
        next[0] = prev[0] ^ temp;
        // the other three columns chain off the column to their left
        for (int i = 1; i < 4; i++)
        begin
            next[i] = next[i-1] ^ prev[i];
        end
        return next;
    endfunction

    always_comb
    begin
        keyBlocks[0] = key;
        for (int r = 1; r <= NUM_ROUNDS; r++)
        begin
            keyBlocks[r] = nextBlock(r, keyBlocks[r-1]);
        end
    end

    // key length equals the round-key length, so the schedule maps straight across
    assign roundKeys = keyBlocks;

endmodule

// File: hw/roundKeyStore.sv
// ******************************
// writes are refused while lock is high
// a write in the start cycle is hidden until that block finishes
// ******************************

`timescale 1ns/1ps

module roundKeyStore
    import aesPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wrEn,
    input  logic       lock,
    input  roundKeys_t roundKeys,
    input  roundIdx_t  rdIdx,
    output block_t     rdKey
);

    roundKeys_t keyRegs;
    roundKeys_t shadowKeys;
    roundKeys_t readKeys;
    logic       holdOld;
    logic       wrAccept;

    assign wrAccept = wrEn && !lock;

    // holdOld marks that the last accepted write may have landed together with a start
    // it stays set for as long as the cipher holds the lock
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            keyRegs <= '0;
            holdOld <= 1'b0;
        end
        else if (wrAccept)
        begin
            keyRegs <= roundKeys;
            holdOld <= 1'b1;
        end
        else if (!lock)
        begin
            holdOld <= 1'b0;
        end
    end

    // copy of the schedule that was live before the last write
    always_ff @(posedge clk)
    begin
        if (wrAccept)
        begin
            shadowKeys <= keyRegs;
        end
    end

    // a block started in the write cycle keeps reading the old schedule
    assign readKeys = (lock && holdOld) ? shadowKeys : keyRegs;

    assign rdKey = (rdIdx <= roundIdx_t'(NUM_ROUNDS)) ? readKeys[rdIdx] : '0;

endmodule

// File: hw/aesCipher.sv
// ******************************
// one block in flight, starts while busy are dropped
// done comes 11 cycles after the accepting edge
// ******************************

`timescale 1ns/1ps

module aesCipher
    import aesPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  block_t    dataIn,
    input  block_t    rdKey,
    output roundIdx_t rdIdx,
    output logic      busy,
    output logic      done,
    output block_t    dataOut
);

    // counter value of the output step that follows round 10
    localparam roundIdx_t OUT_STEP = roundIdx_t'(NUM_ROUNDS + 1);

    aesState_u state;
    aesState_u subState;
    aesState_u shiftState;
    aesState_u mixState;
    aesState_u keyState;
    aesState_u nextState;
    roundIdx_t round;
    logic      lastRound;
    logic      inRound;
    logic      accept;

    // multiply by x in GF(2^8)
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic word_t mixColumn(input word_t col);
        word_t m;
        m[0] = xtime(col[0]) ^ (xtime(col[1]) ^ col[1]) ^ col[2] ^ col[3];
        m[1] = col[0] ^ xtime(col[1]) ^ (xtime(col[2]) ^ col[2]) ^ col[3];
        m[2] = col[0] ^ col[1] ^ xtime(col[2]) ^ (xtime(col[3]) ^ col[3]);
        m[3] = (xtime(col[0]) ^ col[0]) ^ col[1] ^ col[2] ^ xtime(col[3]);
        return m;
    endfunction

    assign accept    = start && !busy;
    assign lastRound = (round == roundIdx_t'(NUM_ROUNDS));
    assign inRound   = busy && (round != '0) && (round != OUT_STEP);
    assign keyState  = rdKey;

    // round 0 is read while idle so the start cycle can add the raw key
    assign rdIdx = (round <= roundIdx_t'(NUM_ROUNDS)) ? round : '0;

    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            subState.bytes[i] = sboxLookup(state.bytes[i]);
        end
    end

    // row r moves left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shiftState.bytes[4*c + r] = subState.bytes[4*((c + r) % 4) + r];
            end
        end
    end

    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mixState.cols[c] = mixColumn(shiftState.cols[c]);
        end
    end

    // the final round has no MixColumns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            nextState.cols[c] = (lastRound ? shiftState.cols[c] : mixState.cols[c])
                                ^ keyState.cols[c];
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            state <= dataIn ^ rdKey;
        end
        else if (inRound)
        begin
            state <= nextState;
        end
    end

    // round counts 1 to 10, then one output step, then busy drops after done
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            round   <= '0;
            dataOut <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (accept)
            begin
                busy  <= 1'b1;
                round <= roundIdx_t'(1);
            end
            else if (busy && done)
            begin
                busy <= 1'b0;
            end
            else if (round == OUT_STEP)
            begin
                dataOut <= state;
                done    <= 1'b1;
                round   <= '0;
            end
            else if (inRound)
            begin
                round <= round + 1'b1;
            end
        end
    end

endmodule

// File: hw/aesTop.sv
// ******************************
// AES-128 encryption only, single-cycle strobes
// keyValid and start are dropped while busy
// ******************************

`timescale 1ns/1ps

module aesTop
    import aesPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   keyValid,
    input  block_t key,
    input  logic   start,
    input  block_t dataIn,
    output logic   busy,
    output logic   done,
    output block_t dataOut
);

    roundKeys_t roundKeys;
    roundIdx_t  rdIdx;
    block_t     rdKey;

    expandKey i_expandKey (
        .key       (key),
        .roundKeys (roundKeys)
    );

    // busy from the cipher doubles as the write lock of the store
    roundKeyStore i_roundKeyStore (
        .clk       (clk),
        .rst       (rst),
        .wrEn      (keyValid),
        .lock      (busy),
        .roundKeys (roundKeys),
        .rdIdx     (rdIdx),
        .rdKey     (rdKey)
    );

    aesCipher i_aesCipher (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .dataIn  (dataIn),
        .rdKey   (rdKey),
        .rdIdx   (rdIdx),
        .busy    (busy),
        .done    (done),
        .dataOut (dataOut)
    );

endmodule

// File: dv/aesTb.sv
// ******************************
// self-checking testbench for aesTop, AES-128 encryption only
// a watchdog ends the run after MAX_CYCLES clock cycles
// ******************************

`timescale 1ns/1ps

module aesTb
    import aesPkg::*;
();

    localparam logic [31:0] SEED = 32'h9c22;
    localparam int DONE_TIMEOUT = 20;
    localparam int MAX_CYCLES = 5000;
    localparam int LATENCY = 11;

    logic   clk;
    logic   rst;
    logic   keyValid;
    block_t key;
    logic   start;
    block_t dataIn;
    logic   busy;
    logic   done;
    block_t dataOut;

    logic [31:0] lfsrState;
    block_t      expQ[$];
    int          errors;
    int          doneCount;
    int          testsRun;
    int          testsFailed;

    aesTop i_aesTop (
        .clk      (clk),
        .rst      (rst),
        .keyValid (keyValid),
        .key      (key),
        .start    (start),
        .dataIn   (dataIn),
        .busy     (busy),
        .done     (done),
        .dataOut  (dataOut)
    );

    always #10 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, one new bit per call
    function automatic logic nextBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic block_t randomBlock();
        block_t b;
        for (int i = 0; i < 128; i++)
        begin
            b = {b[126:0], nextBit()};
        end
        return b;
    endfunction

    function automatic byte_t mul2(input byte_t b);
        return (b << 1) ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // AES-128 straight from FIPS-197, with a word-based key schedule
    function automatic block_t refEncrypt(input block_t k, input block_t pt);
        logic [31:0] w [0:43];
        logic [31:0] tmp;
        byte_t       s [0:15];
        byte_t       t [0:15];
        byte_t       a [0:3];
        byte_t       rc;
        block_t      res;
        rc = 8'h01;
        for (int i = 0; i < 4; i++)
        begin
            w[i] = k[127 - 32*i -: 32];
        end
        for (int i = 4; i < 44; i++)
        begin
            tmp = w[i-1];
            if (i % 4 == 0)
            begin
                tmp = {sboxLookup(tmp[23:16]) ^ rc, sboxLookup(tmp[15:8]),
                       sboxLookup(tmp[7:0]), sboxLookup(tmp[31:24])};
                rc = mul2(rc);
            end
            w[i] = w[i-4] ^ tmp;
        end
        for (int i = 0; i < 16; i++)
        begin
            s[i] = pt[127 - 8*i -: 8] ^ w[i/4][31 - 8*(i%4) -: 8];
        end
        for (int rnd = 1; rnd <= 10; rnd++)
        begin
            for (int i = 0; i < 16; i++)
            begin
                t[i] = sboxLookup(s[i]);
            end
            // byte index is 4*column + row, row r rotates left by r
            for (int c = 0; c < 4; c++)
            begin
                for (int r = 0; r < 4; r++)
                begin
                    s[4*c + r] = t[4*((c + r) % 4) + r];
                end
            end
            if (rnd < 10)
            begin
                for (int c = 0; c < 4; c++)
                begin
                    for (int r = 0; r < 4; r++)
                    begin
                        a[r] = s[4*c + r];
                    end
                    s[4*c]     = mul2(a[0]) ^ mul2(a[1]) ^ a[1] ^ a[2] ^ a[3];
                    s[4*c + 1] = a[0] ^ mul2(a[1]) ^ mul2(a[2]) ^ a[2] ^ a[3];
                    s[4*c + 2] = a[0] ^ a[1] ^ mul2(a[2]) ^ mul2(a[3]) ^ a[3];
                    s[4*c + 3] = mul2(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ mul2(a[3]);
                end
            end
            for (int i = 0; i < 16; i++)
            begin
                s[i] = s[i] ^ w[4*rnd + i/4][31 - 8*(i%4) -: 8];
            end
        end
        for (int i = 0; i < 16; i++)
        begin
            res[127 - 8*i -: 8] = s[i];
        end
        return res;
    endfunction

    task automatic checkValue(input string name, input block_t got, input block_t exp);
        if (got !== exp)
        begin
            $display("ERROR time=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // all drive tasks start and end 2 ns after a rising edge
    task automatic loadKey(input block_t k);
        key = k;
        keyValid = 1'b1;
        @(posedge clk);
        #2;
        keyValid = 1'b0;
    endtask

    task automatic startBlock(input block_t b);
        dataIn = b;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic keyAndStart(input block_t k, input block_t b);
        key = k;
        dataIn = b;
        keyValid = 1'b1;
        start = 1'b1;
        @(posedge clk);
        #2;
        keyValid = 1'b0;
        start = 1'b0;
    endtask

    task automatic idleCycles(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    // counts edges until done is seen, called right after the accepting edge
    task automatic waitDone(output int cycles);
        cycles = 0;
        while (cycles < DONE_TIMEOUT && done !== 1'b1)
        begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (done !== 1'b1)
        begin
            $display("no done within %0d cycles at time %0t", DONE_TIMEOUT, $time);
            errors++;
        end
    endtask

    // lets the checker see the done cycle, then steps to the next edge
    task automatic settleCycle();
        @(negedge clk);
        #1;
        @(posedge clk);
        #2;
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testsRun++;
        if (errors != errBefore)
        begin
            testsFailed++;
        end
        $display("test %0d %s: %s", testsRun, name, (errors == errBefore) ? "ok" : "failed");
    endtask

    // compares every done against the oldest expected ciphertext
    initial
    begin
        block_t expected;
        for (int c = 0; c < MAX_CYCLES; c++)
        begin
            @(negedge clk);
            if (done === 1'b1)
            begin
                doneCount++;
                if (expQ.size() == 0)
                begin
                    $display("done pulsed at time %0t with no encryption pending", $time);
                    errors++;
                end
                else
                begin
                    expected = expQ.pop_front();
                    checkValue("dataOut", dataOut, expected);
                end
            end
        end
    end

    initial
    begin
        for (int c = 0; c < MAX_CYCLES; c++)
        begin
            @(posedge clk);
        end
        $display("simulation hung, still running after %0d cycles", MAX_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        block_t curKey;
        block_t newKey;
        block_t b1;
        block_t b2;
        int     lat;
        int     errBefore;
        int     doneBefore;
        clk = 1'b0;
        rst = 1'b1;
        keyValid = 1'b0;
        key = '0;
        start = 1'b0;
        dataIn = '0;
        lfsrState = SEED;
        errors = 0;
        doneCount = 0;
        testsRun = 0;
        testsFailed = 0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        errBefore = errors;
        checkValue("busy", busy, '0);
        checkValue("done", done, '0);
        checkValue("dataOut", dataOut, '0);
        reportTest("reset state", errBefore);

        // FIPS-197 appendix C.1
        errBefore = errors;
        curKey = 128'h000102030405060708090a0b0c0d0e0f;
        b1 = 128'h00112233445566778899aabbccddeeff;
        checkValue("refEncrypt", refEncrypt(curKey, b1), 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        loadKey(curKey);
        expQ.push_back(128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        startBlock(b1);
        waitDone(lat);
        checkValue("doneLatency", block_t'(lat), block_t'(LATENCY));
        settleCycle();
        reportTest("standard vector", errBefore);

        errBefore = errors;
        for (int n = 0; n < 20; n++)
        begin
            curKey = randomBlock();
            b1 = randomBlock();
            loadKey(curKey);
            expQ.push_back(refEncrypt(curKey, b1));
            startBlock(b1);
            waitDone(lat);
            settleCycle();
        end
        reportTest("random traffic", errBefore);

        errBefore = errors;
        b1 = randomBlock();
        b2 = randomBlock();
        doneBefore = doneCount;
        expQ.push_back(refEncrypt(curKey, b1));
        startBlock(b1);
        idleCycles(3);
        startBlock(b2);
        waitDone(lat);
        idleCycles(15);
        checkValue("doneCount", block_t'(doneCount - doneBefore), block_t'(1));
        reportTest("start while busy", errBefore);

        errBefore = errors;
        newKey = randomBlock();
        b1 = randomBlock();
        b2 = randomBlock();
        expQ.push_back(refEncrypt(curKey, b1));
        startBlock(b1);
        idleCycles(2);
        loadKey(newKey);
        waitDone(lat);
        settleCycle();
        expQ.push_back(refEncrypt(curKey, b2));
        startBlock(b2);
        waitDone(lat);
        settleCycle();
        reportTest("key load while busy", errBefore);

        // the block started with the key load still runs under the old key
        errBefore = errors;
        newKey = randomBlock();
        b1 = randomBlock();
        b2 = randomBlock();
        expQ.push_back(refEncrypt(curKey, b1));
        keyAndStart(newKey, b1);
        waitDone(lat);
        settleCycle();
        curKey = newKey;
        expQ.push_back(refEncrypt(curKey, b2));
        startBlock(b2);
        waitDone(lat);
        settleCycle();
        reportTest("key and start together", errBefore);

        if (expQ.size() != 0)
        begin
            $display("%0d expected results never came out", expQ.size());
            errors++;
        end
        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hw
hw/aesPkg.sv
hw/expandKey.sv
hw/roundKeyStore.sv
hw/aesCipher.sv
hw/aesTop.sv
dv/aesTb.sv

// File: Bender.yml
package:
  name: aes128

sources:
  - include_dirs:
      - hw
    files:
      - hw/aesPkg.sv
      - hw/expandKey.sv
      - hw/roundKeyStore.sv
      - hw/aesCipher.sv
      - hw/aesTop.sv
  - target: test
    files:
      - dv/aesTb.sv
